/* Bender.yml */
package:
  name: tile_host

sources:
  # Design sources in compile order
  - rtl/tile_host_pkg.sv
  - rtl/tile_print_fifo.sv
  - rtl/tile_sentinel_prof.sv
  - rtl/tile_host_regs.sv
  - rtl/tile_host_top.sv

  # Testbench
  - target: test
    files:
      - tb/tile_host_tb.sv

/* filelist.f */
rtl/tile_host_pkg.sv
rtl/tile_print_fifo.sv
rtl/tile_sentinel_prof.sv
rtl/tile_host_regs.sv
rtl/tile_host_top.sv
tb/tile_host_tb.sv

/* rtl/tile_host_pkg.sv */
// Tile host shared types
package tile_host_pkg;

  // Bus geometry
  localparam int unsigned AXIL_ADDR_W = 32;
  localparam int unsigned AXIL_DATA_W = 32;

  // Interrupt lines towards the core
  localparam int unsigned N_IRQ = 16;

  // Sentinel instructions seen in the execute stream
  localparam logic [31:0] SENTINEL_START = 32'h5AA0_0013;
  localparam logic [31:0] SENTINEL_END   = 32'h5FF0_0013;

  // AXI4-Lite response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  // Master to slave channels
  typedef struct packed {
    logic [AXIL_ADDR_W-1:0]   aw_addr;
    logic                     aw_valid;
    logic [AXIL_DATA_W-1:0]   w_data;
    logic [AXIL_DATA_W/8-1:0] w_strb;
    logic                     w_valid;
    logic                     b_ready;
    logic [AXIL_ADDR_W-1:0]   ar_addr;
    logic                     ar_valid;
    logic                     r_ready;
  } axil_req_t;

  // Slave to master channels
  typedef struct packed {
    logic                   aw_ready;
    logic                   w_ready;
    axil_resp_e             b_resp;
    logic                   b_valid;
    logic                   ar_ready;
    logic [AXIL_DATA_W-1:0] r_data;
    axil_resp_e             r_resp;
    logic                   r_valid;
  } axil_rsp_t;

  // Register byte offsets
  typedef enum logic [7:0] {
    REG_CTRL      = 8'h00,
    REG_BOOT      = 8'h04,
    REG_IRQ       = 8'h08,
    REG_STDOUT    = 8'h0C,
    REG_EXIT      = 8'h10,
    REG_STATUS    = 8'h14,
    REG_TIME_LO   = 8'h18,
    REG_TIME_HI   = 8'h1C,
    REG_PROF_LAST = 8'h20,
    REG_PROF_CNT  = 8'h24
  } reg_addr_e;

  // Profiler FSM
  typedef enum logic {
    PROF_IDLE,
    PROF_RUN
  } prof_state_e;

  // Profiler results for the register block
  typedef struct packed {
    logic [31:0] last_lat;
    logic [15:0] pair_cnt;
    logic        orphan_end;
  } prof_stat_t;

endpackage

/* rtl/tile_host_regs.sv */
// Tile host register block
module tile_host_regs
  import tile_host_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic                        clk,
  input  logic                        arst_n_i,
  input  axil_req_t                   axil_req_i,
  output axil_rsp_t                   axil_rsp_o,
  output logic                        push_o,
  output logic [7:0]                  push_char_o,
  output logic                        pop_o,
  input  logic [7:0]                  head_char_i,
  input  logic                        empty_i,
  input  logic [$clog2(FIFO_DEPTH):0] count_i,
  input  logic                        overflow_i,
  input  prof_stat_t                  prof_stat_i,
  output logic                        fetch_enable_o,
  output logic [31:0]                 boot_addr_o,
  output logic [N_IRQ-1:0]            irq_o,
  output logic                        eoc_o,
  output logic [31:0]                 exit_code_o
);

  // Channel handshakes
  logic                   wr_fire;
  logic                   rd_fire;
  logic                   b_valid_q;
  logic                   r_valid_q;
  axil_resp_e             b_resp_q;
  axil_resp_e             r_resp_q;
  logic [AXIL_DATA_W-1:0] r_data_q;
  // Address decode
  reg_addr_e              wr_addr;
  reg_addr_e              rd_addr;
  logic                   wr_hit;
  logic                   rd_hit;
  // Read mux and merged write data
  logic [AXIL_DATA_W-1:0] rd_data;
  logic [31:0]            status;
  logic [31:0]            boot_merged;
  logic [31:0]            irq_merged;
  logic [31:0]            exit_merged;
  // Free-running timer
  logic [63:0]            timer_q;
  logic [31:0]            time_hi_snap_q;

  // Byte-lane merge of write data
  function automatic logic [AXIL_DATA_W-1:0] apply_strb(
    input logic [AXIL_DATA_W-1:0]   old_val,
    input logic [AXIL_DATA_W-1:0]   new_val,
    input logic [AXIL_DATA_W/8-1:0] strb
  );
    logic [AXIL_DATA_W-1:0] res;
    res = old_val;
    for (int i = 0; i < AXIL_DATA_W / 8; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Only the ten listed offsets exist, upper address bits must be zero
  function automatic logic is_mapped(input logic [AXIL_ADDR_W-1:0] addr);
    logic hit;
    case (reg_addr_e'(addr[7:0]))
      REG_CTRL, REG_BOOT, REG_IRQ, REG_STDOUT, REG_EXIT,
      REG_STATUS, REG_TIME_LO, REG_TIME_HI, REG_PROF_LAST, REG_PROF_CNT: hit = 1'b1;
      default: hit = 1'b0;
    endcase
    return hit && (addr[AXIL_ADDR_W-1:8] == '0);
  endfunction

  // AW and W are taken together, once the previous B has gone
  assign wr_fire = axil_req_i.aw_valid && axil_req_i.w_valid && !b_valid_q;
  assign rd_fire = axil_req_i.ar_valid && !r_valid_q;

  assign wr_addr = reg_addr_e'(axil_req_i.aw_addr[7:0]);
  assign rd_addr = reg_addr_e'(axil_req_i.ar_addr[7:0]);
  assign wr_hit  = is_mapped(axil_req_i.aw_addr);
  assign rd_hit  = is_mapped(axil_req_i.ar_addr);

  // Console buffer strobes
  assign push_o      = wr_fire && wr_hit && (wr_addr == REG_STDOUT);
  assign push_char_o = axil_req_i.w_data[7:0];
  assign pop_o       = rd_fire && rd_hit && (rd_addr == REG_STDOUT);

  assign boot_merged = apply_strb(boot_addr_o, axil_req_i.w_data, axil_req_i.w_strb);
  assign irq_merged  = apply_strb(32'(irq_o), axil_req_i.w_data, axil_req_i.w_strb);
  assign exit_merged = apply_strb(exit_code_o, axil_req_i.w_data, axil_req_i.w_strb);

  // Status word and read mux
  always_comb begin
    status       = '0;
    status[0]    = eoc_o;
    status[1]    = overflow_i;
    status[2]    = prof_stat_i.orphan_end;
    status[15:8] = 8'(count_i);
    case (rd_addr)
      REG_CTRL:      rd_data = 32'(fetch_enable_o);
      REG_BOOT:      rd_data = boot_addr_o;
      REG_IRQ:       rd_data = 32'(irq_o);
      // Valid flag in bit 8, head sampled in the pop cycle
      REG_STDOUT:    rd_data = {23'b0, !empty_i, head_char_i};
      REG_EXIT:      rd_data = exit_code_o;
      REG_STATUS:    rd_data = status;
      REG_TIME_LO:   rd_data = timer_q[31:0];
      REG_TIME_HI:   rd_data = time_hi_snap_q;
      REG_PROF_LAST: rd_data = prof_stat_i.last_lat;
      REG_PROF_CNT:  rd_data = 32'(prof_stat_i.pair_cnt);
      default:       rd_data = '0;
    endcase
  end

  // Control registers
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fetch_enable_o <= 1'b0;
      boot_addr_o    <= '0;
      irq_o          <= '0;
      eoc_o          <= 1'b0;
      exit_code_o    <= '0;
    end else if (wr_fire && wr_hit) begin
      case (wr_addr)
        REG_CTRL: begin
          if (axil_req_i.w_strb[0]) begin
            fetch_enable_o <= axil_req_i.w_data[0];
          end
        end
        REG_BOOT: boot_addr_o <= boot_merged;
        REG_IRQ:  irq_o <= irq_merged[N_IRQ-1:0];
        // Exit code write also flags end of computation
        REG_EXIT: begin
          exit_code_o <= exit_merged;
          eoc_o       <= 1'b1;
        end
        // Read-only and console offsets ignore the data here
        default: ;
      endcase
    end
  end

  // Timer and high-word snapshot
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      timer_q        <= '0;
      time_hi_snap_q <= '0;
    end else begin
      timer_q <= timer_q + 64'd1;
      if (rd_fire && rd_hit && (rd_addr == REG_TIME_LO)) begin
        time_hi_snap_q <= timer_q[63:32];
      end
    end
  end

  // Response valid flags
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        b_valid_q <= 1'b1;
      end else if (axil_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_fire) begin
        r_valid_q <= 1'b1;
      end else if (axil_req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // Response payload
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      b_resp_q <= wr_hit ? OKAY : SLVERR;
    end
    if (rd_fire) begin
      r_data_q <= rd_hit ? rd_data : '0;
      r_resp_q <= rd_hit ? OKAY : SLVERR;
    end
  end

  assign axil_rsp_o.aw_ready = wr_fire;
  assign axil_rsp_o.w_ready  = wr_fire;
  assign axil_rsp_o.b_resp   = b_resp_q;
  assign axil_rsp_o.b_valid  = b_valid_q;
  assign axil_rsp_o.ar_ready = !r_valid_q;
  assign axil_rsp_o.r_data   = r_data_q;
  assign axil_rsp_o.r_resp   = r_resp_q;
  assign axil_rsp_o.r_valid  = r_valid_q;

  // Write response held until the master takes it
  a_b_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    b_valid_q && !axil_req_i.b_ready |=> b_valid_q);

  // Read data frozen across back-pressure
  a_r_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
    r_valid_q && !axil_req_i.r_ready |=> $stable(r_data_q));

endmodule

/* rtl/tile_host_top.sv */
// Tile host interface top
module tile_host_top
  import tile_host_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic             clk,
  input  logic             arst_n_i,
  input  axil_req_t        axil_req_i,
  output axil_rsp_t        axil_rsp_o,
  input  logic             instr_valid_i,
  input  logic [31:0]      instr_i,
  output logic             fetch_enable_o,
  output logic [31:0]      boot_addr_o,
  output logic [N_IRQ-1:0] irq_o,
  output logic             eoc_o,
  output logic [31:0]      exit_code_o
);

  // Register block to console buffer
  logic                        push;
  logic [7:0]                  push_char;
  logic                        pop;
  logic [7:0]                  head_char;
  logic                        empty;
  logic [$clog2(FIFO_DEPTH):0] count;
  logic                        overflow;
  // Profiler results
  prof_stat_t                  prof_stat;

  tile_host_regs #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_regs (
    .clk            ( clk            ),
    .arst_n_i       ( arst_n_i       ),
    .axil_req_i     ( axil_req_i     ),
    .axil_rsp_o     ( axil_rsp_o     ),
    .push_o         ( push           ),
    .push_char_o    ( push_char      ),
    .pop_o          ( pop            ),
    .head_char_i    ( head_char      ),
    .empty_i        ( empty          ),
    .count_i        ( count          ),
    .overflow_i     ( overflow       ),
    .prof_stat_i    ( prof_stat      ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    ),
    .irq_o          ( irq_o          ),
    .eoc_o          ( eoc_o          ),
    .exit_code_o    ( exit_code_o    )
  );

  tile_print_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_print_fifo (
    .clk        ( clk       ),
    .arst_n_i   ( arst_n_i  ),
    .push_i     ( push      ),
    .char_i     ( push_char ),
    .pop_i      ( pop       ),
    .head_o     ( head_char ),
    .empty_o    ( empty     ),
    .count_o    ( count     ),
    .overflow_o ( overflow  )
  );

  tile_sentinel_prof i_prof (
    .clk           ( clk           ),
    .arst_n_i      ( arst_n_i      ),
    .instr_valid_i ( instr_valid_i ),
    .instr_i       ( instr_i       ),
    .stat_o        ( prof_stat     )
  );

endmodule

/* rtl/tile_print_fifo.sv */
// Console character buffer
module tile_print_fifo #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic                        clk,
  input  logic                        arst_n_i,
  input  logic                        push_i,
  input  logic [7:0]                  char_i,
  input  logic                        pop_i,
  output logic [7:0]                  head_o,
  output logic                        empty_o,
  output logic [$clog2(FIFO_DEPTH):0] count_o,
  output logic                        overflow_o
);

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

  // Character storage
  logic [7:0]       mem_q [FIFO_DEPTH];
  // Pointers wrap on their own since depth is a power of two
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             full;
  logic             push_ok;
  logic             pop_ok;

  assign full    = (count_q == (PTR_W + 1)'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  assign push_ok = push_i && !full;
  // Pop on empty is a no-op
  assign pop_ok  = pop_i && !empty_o;

  assign head_o  = mem_q[rd_ptr_q];
  assign count_o = count_q;

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= char_i;
    end
  end

  // Pointers, fill level and sticky overflow
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // Dropped character
      if (push_i && full) begin
        overflow_o <= 1'b1;
      end
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (!arst_n_i)
    count_q <= (PTR_W + 1)'(FIFO_DEPTH));

endmodule

/* rtl/tile_sentinel_prof.sv */
// Sentinel latency profiler
module tile_sentinel_prof
  import tile_host_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,
  output prof_stat_t  stat_o
);

  prof_state_e state_q;
  // Local cycle index, counts from reset
  logic [31:0] cyc_q;
  // Cycle index of the open start sentinel
  logic [31:0] start_q;
  logic        is_start;
  logic        is_end;
  prof_stat_t  stat_q;

  // Retired sentinel matches
  assign is_start = instr_valid_i && (instr_i == SENTINEL_START);
  assign is_end   = instr_valid_i && (instr_i == SENTINEL_END);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cyc_q <= '0;
    end else begin
      cyc_q <= cyc_q + 32'd1;
    end
  end

  // Stamp the cycle index of every retired start
  always_ff @(posedge clk) begin
    if (is_start) begin
      start_q <= cyc_q;
    end
  end

  // Pairing FSM and results
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= PROF_IDLE;
      stat_q  <= '0;
    end else begin
      case (state_q)
        PROF_IDLE: begin
          if (is_start) begin
            state_q <= PROF_RUN;
          end else if (is_end) begin
            // End without a start
            stat_q.orphan_end <= 1'b1;
          end
        end
        PROF_RUN: begin
          // A repeated start only restamps start_q and stays here
          if (is_end) begin
            stat_q.last_lat <= cyc_q - start_q;
            stat_q.pair_cnt <= stat_q.pair_cnt + 16'd1;
            state_q         <= PROF_IDLE;
          end
        end
        default: state_q <= PROF_IDLE;
      endcase
    end
  end

  assign stat_o = stat_q;

  // Any end sentinel closes the measurement
  a_end_closes: assert property (@(posedge clk) disable iff (!arst_n_i)
    is_end |=> state_q == PROF_IDLE);

endmodule

/* tb/tile_host_tb.sv */
// Tile host testbench
module tile_host_tb
  import tile_host_pkg::*;
();

  localparam int unsigned FIFO_DEPTH = 8;
  localparam int unsigned SEED       = 16413;

  // Table operations
  typedef enum {OP_WR, OP_RD, OP_OUT, OP_PAIR, OP_END, OP_TIME} op_e;

  // One table row
  // For OP_OUT rows addr selects the output
  typedef struct {
    string       name;
    op_e         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
    logic [31:0] mask;
    axil_resp_e  resp;
  } entry_t;

  logic             clk = 1'b0;
  logic             arst_n_i;
  axil_req_t        axil_req;
  axil_rsp_t        axil_rsp;
  logic             instr_valid;
  logic [31:0]      instr;
  logic             fetch_enable;
  logic [31:0]      boot_addr;
  logic [N_IRQ-1:0] irq;
  logic             eoc;
  logic [31:0]      exit_code;

  entry_t      tbl[$];
  logic        tbl_ready = 1'b0;
  int unsigned errors    = 0;
  int unsigned checks    = 0;
  // Last timer value seen by OP_TIME
  logic [63:0] last_time = '0;

  tile_host_top #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_dut (
    .clk            ( clk          ),
    .arst_n_i       ( arst_n_i     ),
    .axil_req_i     ( axil_req     ),
    .axil_rsp_o     ( axil_rsp     ),
    .instr_valid_i  ( instr_valid  ),
    .instr_i        ( instr        ),
    .fetch_enable_o ( fetch_enable ),
    .boot_addr_o    ( boot_addr    ),
    .irq_o          ( irq          ),
    .eoc_o          ( eoc          ),
    .exit_code_o    ( exit_code    )
  );

  always #5 clk = ~clk;

  function automatic void add_entry(input string name, input op_e op, input logic [31:0] addr,
                                    input logic [31:0] data, input logic [31:0] exp,
                                    input logic [31:0] mask = 32'hFFFF_FFFF,
                                    input axil_resp_e resp = OKAY);
    entry_t e;
    e.name = name;
    e.op   = op;
    e.addr = addr;
    e.data = data;
    e.exp  = exp;
    e.mask = mask;
    e.resp = resp;
    tbl.push_back(e);
  endfunction

  // Random instruction that is never a sentinel
  function automatic logic [31:0] filler_word();
    logic [31:0] word;
    word = $urandom;
    if (word == SENTINEL_START || word == SENTINEL_END) begin
      word = word ^ 32'h1;
    end
    return word;
  endfunction

  // Selected DUT output for OP_OUT rows
  function automatic logic [31:0] dut_output(input logic [31:0] sel);
    case (sel)
      0:       return 32'(fetch_enable);
      1:       return boot_addr;
      2:       return 32'(irq);
      3:       return 32'(eoc);
      4:       return exit_code;
      default: return {30'b0, axil_rsp.b_valid, axil_rsp.r_valid};
    endcase
  endfunction

  function automatic void build_table();
    logic [31:0] code;
    int unsigned n1;
    int unsigned n2;
    code = $urandom;
    n1   = 1 + $urandom_range(0, 19);
    n2   = 1 + $urandom_range(0, 19);
    // Reset state of the outputs
    add_entry("reset fetch_enable", OP_OUT, 0, 0, 0);
    add_entry("reset boot_addr", OP_OUT, 1, 0, 0);
    add_entry("reset irq", OP_OUT, 2, 0, 0);
    add_entry("reset eoc", OP_OUT, 3, 0, 0);
    add_entry("reset exit_code", OP_OUT, 4, 0, 0);
    add_entry("reset resp valids", OP_OUT, 5, 0, 0);
    // Control registers
    add_entry("ctrl write", OP_WR, REG_CTRL, 32'h1, 0);
    add_entry("fetch_enable out", OP_OUT, 0, 0, 32'h1);
    add_entry("ctrl read", OP_RD, REG_CTRL, 0, 32'h1);
    add_entry("boot write", OP_WR, REG_BOOT, 32'h8000_0080, 0);
    add_entry("boot_addr out", OP_OUT, 1, 0, 32'h8000_0080);
    add_entry("boot read", OP_RD, REG_BOOT, 0, 32'h8000_0080);
    add_entry("irq write", OP_WR, REG_IRQ, 32'h0000_A5C3, 0);
    add_entry("irq out", OP_OUT, 2, 0, 32'h0000_A5C3);
    add_entry("irq read", OP_RD, REG_IRQ, 0, 32'h0000_A5C3);
    // Unmapped offsets
    // The aliased write must leave boot untouched
    add_entry("unmapped write", OP_WR, 32'h40, 32'hDEAD_BEEF, 0, '1, SLVERR);
    add_entry("aliased write", OP_WR, 32'h104, 32'h0, 0, '1, SLVERR);
    add_entry("unmapped read", OP_RD, 32'h28, 0, 0, '1, SLVERR);
    add_entry("boot after alias", OP_RD, REG_BOOT, 0, 32'h8000_0080);
    // Console buffer drains in order and then reads empty
    add_entry("empty stdout", OP_RD, REG_STDOUT, 0, 0, 32'h100);
    add_entry("push H", OP_WR, REG_STDOUT, "H", 0);
    add_entry("push i", OP_WR, REG_STDOUT, "i", 0);
    add_entry("push !", OP_WR, REG_STDOUT, "!", 0);
    add_entry("pop H", OP_RD, REG_STDOUT, 0, 32'h100 | "H");
    add_entry("pop i", OP_RD, REG_STDOUT, 0, 32'h100 | "i");
    add_entry("pop !", OP_RD, REG_STDOUT, 0, 32'h100 | "!");
    add_entry("drained stdout", OP_RD, REG_STDOUT, 0, 0, 32'h100);
    add_entry("status clean", OP_RD, REG_STATUS, 0, 32'h0);
    // Overfill by two and keep only the first FIFO_DEPTH
    for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
      add_entry($sformatf("fill %0d", i), OP_WR, REG_STDOUT, 32'("a" + i), 0);
    end
    add_entry("status overflow", OP_RD, REG_STATUS, 0, {16'h0, 8'(FIFO_DEPTH), 8'h2});
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      add_entry($sformatf("drain %0d", i), OP_RD, REG_STDOUT, 0, 32'h100 | 32'("a" + i));
    end
    add_entry("overflow emptied", OP_RD, REG_STDOUT, 0, 0, 32'h100);
    // End of computation
    add_entry("exit write", OP_WR, REG_EXIT, code, 0);
    add_entry("eoc out", OP_OUT, 3, 0, 32'h1);
    add_entry("exit_code out", OP_OUT, 4, 0, code);
    add_entry("exit read", OP_RD, REG_EXIT, 0, code);
    add_entry("status eoc", OP_RD, REG_STATUS, 0, 32'h3);
    // Timer pairs with data as the idle wait before each pair
    add_entry("time first", OP_TIME, 0, 0, 0);
    add_entry("time second", OP_TIME, 0, 20, 0);
    // Sentinel profiler with data as the filler count
    add_entry("prof cnt idle", OP_RD, REG_PROF_CNT, 0, 0);
    add_entry("pair one", OP_PAIR, 0, n1, 0);
    add_entry("prof last one", OP_RD, REG_PROF_LAST, 0, n1 + 1);
    add_entry("prof cnt one", OP_RD, REG_PROF_CNT, 0, 1);
    add_entry("pair two", OP_PAIR, 0, n2, 0);
    add_entry("prof last two", OP_RD, REG_PROF_LAST, 0, n2 + 1);
    add_entry("prof cnt two", OP_RD, REG_PROF_CNT, 0, 2);
    // Lone end sentinel
    add_entry("orphan end", OP_END, 0, 0, 0);
    add_entry("status orphan", OP_RD, REG_STATUS, 0, 32'h7);
    add_entry("prof cnt orphan", OP_RD, REG_PROF_CNT, 0, 2);
    add_entry("prof last orphan", OP_RD, REG_PROF_LAST, 0, n2 + 1);
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act, input logic [31:0] mask);
    checks++;
    if ((act & mask) !== (exp & mask)) begin
      errors++;
      $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, exp & mask, act & mask);
    end
  endtask

  // Write with a random B back-pressure of up to 3 cycles
  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int unsigned delay;
    delay = $urandom_range(0, 3);
    axil_req.aw_addr  <= addr;
    axil_req.aw_valid <= 1'b1;
    axil_req.w_data   <= data;
    axil_req.w_strb   <= 4'hF;
    axil_req.w_valid  <= 1'b1;
    do begin
      @(posedge clk);
    end while (!axil_rsp.aw_ready);
    // W is accepted in the same cycle as AW
    checks++;
    if (!axil_rsp.w_ready) begin
      errors++;
      $display("ERROR: w_ready stayed low while aw_ready was high for address 0x%08h", addr);
    end
    axil_req.aw_valid <= 1'b0;
    axil_req.w_valid  <= 1'b0;
    repeat (delay) @(posedge clk);
    axil_req.b_ready <= 1'b1;
    do begin
      @(posedge clk);
    end while (!axil_rsp.b_valid);
    resp = axil_rsp.b_resp;
    axil_req.b_ready <= 1'b0;
  endtask

  // Read with a random R back-pressure of up to 3 cycles
  task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int unsigned delay;
    delay = $urandom_range(0, 3);
    axil_req.ar_addr  <= addr;
    axil_req.ar_valid <= 1'b1;
    do begin
      @(posedge clk);
    end while (!axil_rsp.ar_ready);
    axil_req.ar_valid <= 1'b0;
    repeat (delay) @(posedge clk);
    axil_req.r_ready <= 1'b1;
    do begin
      @(posedge clk);
    end while (!axil_rsp.r_valid);
    data = axil_rsp.r_data;
    resp = axil_rsp.r_resp;
    axil_req.r_ready <= 1'b0;
  endtask

  // One retired instruction per call
  task automatic retire(input logic [31:0] word);
    instr_valid <= 1'b1;
    instr       <= word;
    @(posedge clk);
  endtask

  task automatic run_entry(input entry_t e);
    logic [1:0]  resp;
    logic [31:0] data;
    logic [31:0] lo;
    logic [31:0] hi;
    case (e.op)
      OP_WR: begin
        axil_write(e.addr, e.data, resp);
        check_value({e.name, " resp"}, 32'(e.resp), 32'(resp), 32'h3);
      end
      OP_RD: begin
        axil_read(e.addr, data, resp);
        check_value({e.name, " resp"}, 32'(e.resp), 32'(resp), 32'h3);
        check_value(e.name, e.exp, data, e.mask);
      end
      // Outputs sampled at an edge settle after the previous one
      OP_OUT: begin
        @(posedge clk);
        check_value(e.name, e.exp, dut_output(e.addr), e.mask);
      end
      OP_PAIR: begin
        retire(SENTINEL_START);
        repeat (e.data) retire(filler_word());
        retire(SENTINEL_END);
        instr_valid <= 1'b0;
        @(posedge clk);
      end
      OP_END: begin
        retire(SENTINEL_END);
        instr_valid <= 1'b0;
        @(posedge clk);
      end
      default: begin
        repeat (e.data) @(posedge clk);
        axil_read(REG_TIME_LO, lo, resp);
        axil_read(REG_TIME_HI, hi, resp);
        checks++;
        if ({hi, lo} <= last_time) begin
          errors++;
          $display("FAIL %s: expected above 0x%016h, actual 0x%016h", e.name, last_time,
                   {hi, lo});
        end
        last_time = {hi, lo};
      end
    endcase
  endtask

  initial begin
    void'($urandom(SEED));
    arst_n_i    <= 1'b0;
    axil_req    <= '0;
    instr_valid <= 1'b0;
    instr       <= '0;
    build_table();
    tbl_ready = 1'b1;
    repeat (2) @(posedge clk);
    arst_n_i <= 1'b1;
    @(posedge clk);
    foreach (tbl[i]) begin
      run_entry(tbl[i]);
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog scaled by the table length
  initial begin
    wait (tbl_ready);
    repeat (tbl.size() * 200) @(posedge clk);
    $display("ERROR: watchdog expired before the test table completed");
    $display("TEST FAILED");
    $finish;
  end

endmodule
